// ==== project.f ====
+incdir+common
common/udp_rx_pkg.sv
verilog/data_masker.sv
verilog/udp_port_table.sv
udp_rx_noc_out/udp_rx_noc_out_ctrl.sv
udp_rx_noc_out/udp_rx_noc_out_datap.sv
verilog/udp_rx_noc_out.sv
dv/udp_rx_noc_out_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile the testbench with Verilator, run it and check the log.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module udp_rx_noc_out_tb -o udp_rx_noc_out_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/udp_rx_noc_out_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q -F '*** TEST PASSED ***' sim.log; then
    exit 0
fi
exit 1

// ==== dv/udp_rx_noc_out_tb.sv ====
`default_nettype none

`include "udp_rx_settings.svh"

module udp_rx_noc_out_tb;

    import udp_rx_pkg::*;

    localparam int SRC_X          = 3;
    localparam int SRC_Y          = 5;
    localparam int NUM_PACKETS    = 40;
    localparam int TIMEOUT_CYCLES = NUM_PACKETS * 200 + 100;
    localparam int DRAIN_CYCLES   = 200;

    logic                         clk = 1'b0;
    logic                         rst;
    logic                         hdr_val;
    udp_rx_hdr_in                 hdr_in;
    logic                         hdr_rdy;
    logic                         data_val;
    udp_rx_data_in                data_in;
    logic                         data_rdy;
    logic                         noc_val;
    logic [`NOC_DATA_WIDTH-1:0]   noc_data;
    logic                         noc_rdy;
    logic                         table_wr_val;
    logic [`PORT_TABLE_IDX_W-1:0] table_wr_index;
    logic [`PORT_NUM_W-1:0]       table_wr_port;
    port_table_entry              table_wr_entry;

    logic [31:0]                lfsr;
    int                         cycle_count;
    int                         check_errors;
    int                         other_errors;
    int                         flits_expected;
    int                         flits_seen;
    logic                       stalled;
    logic [`NOC_DATA_WIDTH-1:0] held_data;

    // expected NoC flits in order, with the flag for the last payload beat
    logic [`NOC_DATA_WIDTH-1:0] exp_flits [$];
    logic                       exp_last [$];

    logic [`PORT_NUM_W-1:0] mapped_ports [4];
    port_table_entry        mapped_dest [4];
    logic [`PORT_NUM_W-1:0] unmapped_ports [4];

    udp_rx_noc_out #(
        .SRC_X (SRC_X),
        .SRC_Y (SRC_Y)
    ) UUT (
        .clk            (clk),
        .rst            (rst),
        .hdr_val        (hdr_val),
        .hdr            (hdr_in),
        .hdr_rdy        (hdr_rdy),
        .data_val       (data_val),
        .data           (data_in),
        .data_rdy       (data_rdy),
        .noc_val        (noc_val),
        .noc_data       (noc_data),
        .noc_rdy        (noc_rdy),
        .table_wr_val   (table_wr_val),
        .table_wr_index (table_wr_index),
        .table_wr_port  (table_wr_port),
        .table_wr_entry (table_wr_entry)
    );

    always #20 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // random numbers and expected flits
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [`NOC_DATA_WIDTH-1:0] rand_flit();
        logic [`NOC_DATA_WIDTH-1:0] f;
        for (int w = 0; w < `NOC_DATA_WIDTH / 32; w++) begin
            f[w*32 +: 32] = rand_bits(32);
        end
        return f;
    endfunction

    function automatic logic [`NOC_DATA_WIDTH-1:0] expected_hdr_flit(input udp_rx_hdr_in h,
                                                                     input port_table_entry dest);
        noc_hdr_flit f;
        int          payload;
        payload          = int'(h.udp_hdr.length) - `UDP_HDR_BYTES;
        f                = '0;
        f.dst_x          = dest.x;
        f.dst_y          = dest.y;
        f.dst_fbits      = dest.fbits;
        f.msg_len        = `MSG_LEN_W'(1 + (payload + 15) / 16);
        f.src_x          = `XY_WIDTH'(SRC_X);
        f.src_y          = `XY_WIDTH'(SRC_Y);
        f.src_fbits      = `PKT_IF_FBITS;
        f.msg_type       = UDP_RX_SEGMENT;
        f.packet_id      = h.stats.packet_id;
        f.timestamp      = h.stats.timestamp;
        f.metadata_flits = 8'd1;
        return f;
    endfunction

    // byte i counts from the most significant end and the pad bytes are the last ones
    function automatic logic [`NOC_DATA_WIDTH-1:0] expected_last_beat(
            input logic [`NOC_DATA_WIDTH-1:0] d, input int pad);
        logic [`NOC_DATA_WIDTH-1:0] m;
        m = d;
        for (int i = 16 - pad; i < 16; i++) begin
            m[127 - 8*i -: 8] = 8'h00;
        end
        return m;
    endfunction

    task automatic push_expected(input logic [`NOC_DATA_WIDTH-1:0] f, input logic is_last);
        exp_flits.push_back(f);
        exp_last.push_back(is_last);
        flits_expected++;
    endtask

    task automatic print_counts();
        $display("counts: %0d value errors, %0d other errors, %0d of %0d flits seen",
                 check_errors, other_errors, flits_seen, flits_expected);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // drivers on the falling clock edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic next_negedge();
        @(negedge clk);
        noc_rdy = (rand_bits(2) != 0);
    endtask

    task automatic write_table_entry(input int idx, input logic [`PORT_NUM_W-1:0] port,
                                     input port_table_entry entry);
        next_negedge();
        table_wr_val   = 1'b1;
        table_wr_index = `PORT_TABLE_IDX_W'(idx);
        table_wr_port  = port;
        table_wr_entry = entry;
        @(posedge clk);
    endtask

    task automatic send_header(input udp_rx_hdr_in h);
        next_negedge();
        hdr_val = 1'b1;
        hdr_in  = h;
        @(posedge clk);
        while (!hdr_rdy) begin
            next_negedge();
            @(posedge clk);
        end
        next_negedge();
        hdr_val = 1'b0;
        @(posedge clk);
    endtask

    task automatic send_beat(input logic [`NOC_DATA_WIDTH-1:0] d, input logic is_last,
                             input int pad);
        int gap;
        gap = (rand_bits(1) == 0) ? 0 : int'(rand_bits(2));
        repeat (gap) begin
            next_negedge();
            data_val = 1'b0;
            @(posedge clk);
        end
        next_negedge();
        data_val         = 1'b1;
        data_in.data     = d;
        data_in.last     = is_last;
        // padbytes on earlier beats must have no effect
        data_in.padbytes = is_last ? `PADBYTES_W'(pad) : `PADBYTES_W'(rand_bits(4));
        @(posedge clk);
        while (!data_rdy) begin
            next_negedge();
            @(posedge clk);
        end
    endtask

    task automatic send_packet(input int n);
        udp_rx_hdr_in               h;
        udp_rx_meta_flit            meta;
        logic [`NOC_DATA_WIDTH-1:0] beats [$];
        int                         payload;
        int                         num_beats;
        int                         pad;
        int                         sel;
        logic                       mapped;

        payload = int'(rand_bits(7)) % 93;
        if (n % 7 == 3) begin
            payload = 0;
        end else if (n % 9 == 4) begin
            payload = 48;
        end
        sel    = int'(rand_bits(2));
        mapped = (rand_bits(3) != 0) && (n % 13 != 6);

        h.src_ip            = rand_bits(32);
        h.dst_ip            = rand_bits(32);
        h.udp_hdr.src_port  = rand_bits(16);
        h.udp_hdr.dst_port  = mapped ? mapped_ports[sel] : unmapped_ports[sel];
        h.udp_hdr.length    = 16'(payload + `UDP_HDR_BYTES);
        h.udp_hdr.checksum  = rand_bits(16);
        h.stats.packet_id   = 16'(n);
        h.stats.timestamp   = rand_bits(32);

        num_beats = (payload + 15) / 16;
        pad       = num_beats * 16 - payload;
        for (int b = 0; b < num_beats; b++) begin
            beats.push_back(rand_flit());
        end

        if (mapped) begin
            push_expected(expected_hdr_flit(h, mapped_dest[sel]), 1'b0);
            meta             = '0;
            meta.src_ip      = h.src_ip;
            meta.dst_ip      = h.dst_ip;
            meta.src_port    = h.udp_hdr.src_port;
            meta.dst_port    = h.udp_hdr.dst_port;
            meta.data_length = 16'(payload);
            push_expected(meta, 1'b0);
            for (int b = 0; b < num_beats; b++) begin
                if (b == num_beats - 1) begin
                    push_expected(expected_last_beat(beats[b], pad), 1'b1);
                end else begin
                    push_expected(beats[b], 1'b0);
                end
            end
        end

        send_header(h);
        for (int b = 0; b < num_beats; b++) begin
            send_beat(beats[b], b == num_beats - 1, pad);
        end
        if (num_beats > 0) begin
            next_negedge();
            data_val = 1'b0;
            @(posedge clk);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks on the NoC port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin
        if (!rst && noc_val && noc_rdy) begin
            if (exp_flits.size() == 0) begin
                other_errors++;
                $display("NoC transfer at cycle %0d while no flit was expected", cycle_count);
            end else begin
                assert (noc_data == exp_flits[0]) else begin
                    check_errors++;
                    $display("CHECK FAILED noc_data: got %h expected %h",
                             noc_data, exp_flits[0]);
                end
                // the last flit must leave together with the input beat marked last
                assert ((data_val && data_rdy && data_in.last) == exp_last[0]) else begin
                    check_errors++;
                    $display("CHECK FAILED data.last at transfer: got %h expected %h",
                             data_val && data_rdy && data_in.last, exp_last[0]);
                end
                void'(exp_flits.pop_front());
                void'(exp_last.pop_front());
                flits_seen++;
            end
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            stalled <= 1'b0;
        end else begin
            if (stalled) begin
                assert (noc_val) else begin
                    other_errors++;
                    $display("noc_val dropped at cycle %0d before the flit was taken",
                             cycle_count);
                end
                assert (noc_data == held_data) else begin
                    check_errors++;
                    $display("CHECK FAILED noc_data while stalled: got %h expected %h",
                             noc_data, held_data);
                end
            end
            stalled   <= noc_val && !noc_rdy;
            held_data <= noc_data;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("timeout after %0d cycles with %0d flits still expected",
                 cycle_count, exp_flits.size());
        print_counts();
        $display("*** TEST FAILED ***");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        port_table_entry dead_entry;
        int              drain;

        rst            = 1'b1;
        hdr_val        = 1'b0;
        hdr_in         = '0;
        data_val       = 1'b0;
        data_in        = '0;
        noc_rdy        = 1'b0;
        table_wr_val   = 1'b0;
        table_wr_index = '0;
        table_wr_port  = '0;
        table_wr_entry = '0;
        lfsr           = 32'h1f5431d2;

        mapped_ports   = '{16'h0035, 16'h1f90, 16'h2328, 16'hc350};
        // 16'h1234 gets a table slot with its valid bit clear
        unmapped_ports = '{16'h0050, 16'h01bb, 16'h1234, 16'h0043};

        repeat (8) @(posedge clk);
        next_negedge();
        // idle after reset takes headers and holds the data and NoC sides off
        assert ({hdr_rdy, data_rdy, noc_val} == 3'b100) else begin
            check_errors++;
            $display("CHECK FAILED {hdr_rdy,data_rdy,noc_val}: got %h expected %h",
                     {hdr_rdy, data_rdy, noc_val}, 3'b100);
        end
        rst = 1'b0;
        @(posedge clk);

        for (int i = 0; i < 4; i++) begin
            mapped_dest[i].valid = 1'b1;
            mapped_dest[i].x     = rand_bits(4);
            mapped_dest[i].y     = rand_bits(4);
            mapped_dest[i].fbits = rand_bits(4);
            write_table_entry(i, mapped_ports[i], mapped_dest[i]);
        end
        dead_entry       = '0;
        dead_entry.x     = 4'hf;
        write_table_entry(6, 16'h1234, dead_entry);
        next_negedge();
        table_wr_val = 1'b0;
        @(posedge clk);

        for (int n = 0; n < NUM_PACKETS; n++) begin
            send_packet(n);
        end

        // keep noc_rdy moving until the last flits have left
        drain = 0;
        while (exp_flits.size() != 0 && drain < DRAIN_CYCLES) begin
            next_negedge();
            @(posedge clk);
            drain++;
        end
        repeat (4) @(posedge clk);

        if (exp_flits.size() != 0) begin
            other_errors++;
            $display("%0d expected flits never left the NoC port", exp_flits.size());
        end
        print_counts();
        if (check_errors + other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/udp_rx_noc_out.sv ====
`default_nettype none

`include "udp_rx_settings.svh"

module udp_rx_noc_out #(
    parameter int SRC_X = 0,
    parameter int SRC_Y = 0
) (
    input  logic                         clk,
    input  logic                         rst,

    input  logic                         hdr_val,
    input  udp_rx_pkg::udp_rx_hdr_in     hdr,
    output logic                         hdr_rdy,

    input  logic                         data_val,
    input  udp_rx_pkg::udp_rx_data_in    data,
    output logic                         data_rdy,

    output logic                         noc_val,
    output logic [`NOC_DATA_WIDTH-1:0]   noc_data,
    input  logic                         noc_rdy,

    input  logic                         table_wr_val,
    input  logic [`PORT_TABLE_IDX_W-1:0] table_wr_index,
    input  logic [`PORT_NUM_W-1:0]       table_wr_port,
    input  udp_rx_pkg::port_table_entry  table_wr_entry
);

    import udp_rx_pkg::*;

    logic                   store_inputs;
    flit_sel                sel;
    logic                   last_output;
    logic                   no_data;
    logic                   port_hit;
    logic [`PORT_NUM_W-1:0] lookup_port;
    port_table_entry        lookup_entry;

    udp_rx_noc_out_ctrl ctrl (
        .clk          (clk),
        .rst          (rst),
        .hdr_val      (hdr_val),
        .hdr_rdy      (hdr_rdy),
        .data_val     (data_val),
        .data_rdy     (data_rdy),
        .noc_val      (noc_val),
        .noc_rdy      (noc_rdy),
        .store_inputs (store_inputs),
        .flit_sel     (sel),
        .last_output  (last_output),
        .no_data      (no_data),
        .port_hit     (port_hit)
    );

    udp_rx_noc_out_datap #(
        .SRC_X (SRC_X),
        .SRC_Y (SRC_Y)
    ) datap (
        .clk          (clk),
        .rst          (rst),
        .hdr          (hdr),
        .data         (data),
        .noc_data     (noc_data),
        .store_inputs (store_inputs),
        .flit_sel     (sel),
        .last_output  (last_output),
        .no_data      (no_data),
        .port_hit     (port_hit),
        .lookup_port  (lookup_port),
        .lookup_entry (lookup_entry)
    );

    // the hit flag reaches the controller through the entry's valid bit
    udp_port_table port_table (
        .clk          (clk),
        .rst          (rst),
        .wr_val       (table_wr_val),
        .wr_index     (table_wr_index),
        .wr_port      (table_wr_port),
        .wr_entry     (table_wr_entry),
        .lookup_port  (lookup_port),
        .lookup_entry (lookup_entry),
        .lookup_hit   ()
    );

endmodule

`default_nettype wire

// ==== udp_rx_noc_out/udp_rx_noc_out_datap.sv ====
`default_nettype none

`include "udp_rx_settings.svh"

module udp_rx_noc_out_datap #(
    parameter int SRC_X = 0,
    parameter int SRC_Y = 0
) (
    input  logic                        clk,
    input  logic                        rst,

    input  udp_rx_pkg::udp_rx_hdr_in    hdr,
    input  udp_rx_pkg::udp_rx_data_in   data,

    output logic [`NOC_DATA_WIDTH-1:0]  noc_data,

    input  logic                        store_inputs,
    input  udp_rx_pkg::flit_sel         flit_sel,

    output logic                        last_output,
    output logic                        no_data,
    output logic                        port_hit,

    output logic [`PORT_NUM_W-1:0]      lookup_port,
    input  udp_rx_pkg::port_table_entry lookup_entry
);

    import udp_rx_pkg::*;

    udp_rx_hdr_in hdr_r;
    udp_rx_hdr_in hdr_next;

    logic [`UDP_LENGTH_W-1:0]   data_size;
    logic [`UDP_LENGTH_W-1:0]   num_data_flits;
    logic [`NOC_DATA_WIDTH-1:0] masked_data;

    noc_hdr_flit     hdr_flit;
    udp_rx_meta_flit meta_flit;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // header register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign hdr_next = store_inputs ? hdr : hdr_r;

    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_r <= '0;
        end else begin
            hdr_r <= hdr_next;
        end
    end

    // lookup and status follow the incoming header in the accept cycle
    assign lookup_port = hdr_next.udp_hdr.dst_port;
    assign port_hit    = lookup_entry.valid;
    assign no_data     = hdr_next.udp_hdr.length == `UDP_LENGTH_W'(`UDP_HDR_BYTES);
    assign last_output = data.last;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lengths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign data_size = hdr_r.udp_hdr.length - `UDP_LENGTH_W'(`UDP_HDR_BYTES);

    // round up to whole flits
    assign num_data_flits = (data_size[`NOC_DATA_BYTES_W-1:0] == '0)
                          ? (data_size >> `NOC_DATA_BYTES_W)
                          : (data_size >> `NOC_DATA_BYTES_W) + 1'b1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // flit builders
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        hdr_flit = '0;

        hdr_flit.dst_x     = lookup_entry.x;
        hdr_flit.dst_y     = lookup_entry.y;
        hdr_flit.dst_fbits = lookup_entry.fbits;

        // one metadata flit ahead of the payload
        hdr_flit.msg_len   = `MSG_LEN_W'(num_data_flits + 1'b1);

        hdr_flit.src_x     = `XY_WIDTH'(SRC_X);
        hdr_flit.src_y     = `XY_WIDTH'(SRC_Y);
        hdr_flit.src_fbits = `PKT_IF_FBITS;
        hdr_flit.msg_type  = UDP_RX_SEGMENT;

        hdr_flit.packet_id      = hdr_r.stats.packet_id;
        hdr_flit.timestamp      = hdr_r.stats.timestamp;
        hdr_flit.metadata_flits = 8'd1;
    end

    always_comb begin
        meta_flit = '0;

        meta_flit.src_ip      = hdr_r.src_ip;
        meta_flit.dst_ip      = hdr_r.dst_ip;
        meta_flit.src_port    = hdr_r.udp_hdr.src_port;
        meta_flit.dst_port    = hdr_r.udp_hdr.dst_port;
        meta_flit.data_length = data_size;
    end

    data_masker #(
        .width (`NOC_DATA_WIDTH)
    ) masker (
        .unmasked_data (data.data),
        .padbytes      (data.padbytes),
        .last          (data.last),
        .masked_data   (masked_data)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output select
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (flit_sel)
            SEL_HDR_FLIT:  noc_data = hdr_flit;
            SEL_META_FLIT: noc_data = meta_flit;
            default:       noc_data = masked_data;
        endcase
    end

endmodule

`default_nettype wire

// ==== udp_rx_noc_out/udp_rx_noc_out_ctrl.sv ====
`default_nettype none

module udp_rx_noc_out_ctrl (
    input  logic              clk,
    input  logic              rst,

    input  logic              hdr_val,
    output logic              hdr_rdy,
    input  logic              data_val,
    output logic              data_rdy,
    output logic              noc_val,
    input  logic              noc_rdy,

    output logic              store_inputs,
    output udp_rx_pkg::flit_sel flit_sel,

    input  logic              last_output,
    input  logic              no_data,
    input  logic              port_hit
);

    import udp_rx_pkg::*;

    noc_out_state state_r;
    noc_out_state state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_r <= IDLE;
        end else begin
            state_r <= state_next;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // outputs and next state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        state_next   = state_r;
        hdr_rdy      = 1'b0;
        data_rdy     = 1'b0;
        noc_val      = 1'b0;
        store_inputs = 1'b0;
        flit_sel     = SEL_DATA_FLIT;

        case (state_r)
            IDLE: begin
                hdr_rdy = 1'b1;
                if (hdr_val) begin
                    store_inputs = 1'b1;
                    // hit and no_data already reflect the incoming header here
                    if (port_hit) begin
                        state_next = HDR;
                    end else if (!no_data) begin
                        state_next = DROP;
                    end
                end
            end
            HDR: begin
                noc_val  = 1'b1;
                flit_sel = SEL_HDR_FLIT;
                if (noc_rdy) begin
                    state_next = META;
                end
            end
            META: begin
                noc_val  = 1'b1;
                flit_sel = SEL_META_FLIT;
                if (noc_rdy) begin
                    state_next = no_data ? IDLE : DATA;
                end
            end
            DATA: begin
                // payload beats pass straight through to the NoC port
                noc_val  = data_val;
                data_rdy = noc_rdy;
                flit_sel = SEL_DATA_FLIT;
                if (data_val && noc_rdy && last_output) begin
                    state_next = IDLE;
                end
            end
            DROP: begin
                // unmapped port so sink every beat without sending
                data_rdy = 1'b1;
                if (data_val && last_output) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/udp_port_table.sv ====
`default_nettype none

`include "udp_rx_settings.svh"

module udp_port_table (
    input  logic                           clk,
    input  logic                           rst,

    input  logic                           wr_val,
    input  logic [`PORT_TABLE_IDX_W-1:0]   wr_index,
    input  logic [`PORT_NUM_W-1:0]         wr_port,
    input  udp_rx_pkg::port_table_entry    wr_entry,

    input  logic [`PORT_NUM_W-1:0]         lookup_port,
    output udp_rx_pkg::port_table_entry    lookup_entry,
    output logic                           lookup_hit
);

    import udp_rx_pkg::*;

    logic [`PORT_TABLE_DEPTH-1:0] valid_r;
    logic [`PORT_NUM_W-1:0]       port_r [`PORT_TABLE_DEPTH];
    port_table_entry              dest_r [`PORT_TABLE_DEPTH];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_r <= '0;
        end else if (wr_val) begin
            valid_r[wr_index] <= wr_entry.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_val) begin
            port_r[wr_index] <= wr_port;
            dest_r[wr_index] <= wr_entry;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lookup, lowest matching index wins
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        lookup_hit   = 1'b0;
        lookup_entry = '0;
        for (int i = 0; i < `PORT_TABLE_DEPTH; i++) begin
            if (!lookup_hit && valid_r[i] && (port_r[i] == lookup_port)) begin
                lookup_hit         = 1'b1;
                lookup_entry       = dest_r[i];
                lookup_entry.valid = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/data_masker.sv ====
`default_nettype none

module data_masker #(
    parameter int width = 128
) (
    input  logic [width-1:0]                 unmasked_data,
    input  logic [$clog2(width/8)-1:0]       padbytes,
    input  logic                             last,
    output logic [width-1:0]                 masked_data
);

    localparam int NUM_BYTES = width / 8;

    logic [width-1:0] byte_mask;

    // byte j here counts from the least significant end, so the
    // pad bytes are the lowest padbytes of them
    always_comb begin
        for (int j = 0; j < NUM_BYTES; j++) begin
            if (last && (j < int'(padbytes))) begin
                byte_mask[j*8 +: 8] = 8'h00;
            end else begin
                byte_mask[j*8 +: 8] = 8'hff;
            end
        end
    end

    assign masked_data = unmasked_data & byte_mask;

endmodule

`default_nettype wire

// ==== common/udp_rx_pkg.sv ====
`default_nettype none

`include "udp_rx_settings.svh"

package udp_rx_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // inputs from the UDP formatter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic [`PORT_NUM_W-1:0]   src_port;
        logic [`PORT_NUM_W-1:0]   dst_port;
        logic [`UDP_LENGTH_W-1:0] length;
        logic [15:0]              checksum;
    } udp_pkt_hdr;

    typedef struct packed {
        logic [15:0] packet_id;
        logic [31:0] timestamp;
    } tracker_stats;

    typedef struct packed {
        logic [`IP_ADDR_W-1:0] src_ip;
        logic [`IP_ADDR_W-1:0] dst_ip;
        udp_pkt_hdr            udp_hdr;
        tracker_stats          stats;
    } udp_rx_hdr_in;

    typedef struct packed {
        logic [`NOC_DATA_WIDTH-1:0] data;
        logic                       last;
        logic [`PADBYTES_W-1:0]     padbytes;
    } udp_rx_data_in;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // NoC message flits
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [7:0] {
        UDP_RX_SEGMENT = 8'h12
    } noc_msg_type;

    // the used fields take 96 bits, the rest of the flit is zero
    typedef struct packed {
        logic [`XY_WIDTH-1:0]  dst_x;
        logic [`XY_WIDTH-1:0]  dst_y;
        logic [`FBITS_W-1:0]   dst_fbits;
        logic [`MSG_LEN_W-1:0] msg_len;
        logic [`XY_WIDTH-1:0]  src_x;
        logic [`XY_WIDTH-1:0]  src_y;
        logic [`FBITS_W-1:0]   src_fbits;
        noc_msg_type           msg_type;
        logic [15:0]           packet_id;
        logic [31:0]           timestamp;
        logic [7:0]            metadata_flits;
        logic [`NOC_DATA_WIDTH-97:0] padding;
    } noc_hdr_flit;

    typedef struct packed {
        logic [`IP_ADDR_W-1:0]    src_ip;
        logic [`IP_ADDR_W-1:0]    dst_ip;
        logic [`PORT_NUM_W-1:0]   src_port;
        logic [`PORT_NUM_W-1:0]   dst_port;
        logic [`UDP_LENGTH_W-1:0] data_length;
        logic [`NOC_DATA_WIDTH-113:0] padding;
    } udp_rx_meta_flit;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // port table and control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic                 valid;
        logic [`XY_WIDTH-1:0] x;
        logic [`XY_WIDTH-1:0] y;
        logic [`FBITS_W-1:0]  fbits;
    } port_table_entry;

    typedef enum logic [1:0] {
        SEL_HDR_FLIT,
        SEL_META_FLIT,
        SEL_DATA_FLIT
    } flit_sel;

    typedef enum logic [2:0] {
        IDLE,
        HDR,
        META,
        DATA,
        DROP
    } noc_out_state;

endpackage

`default_nettype wire

// ==== common/udp_rx_settings.svh ====
`ifndef UDP_RX_SETTINGS_SVH
`define UDP_RX_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// packet field widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define IP_ADDR_W           32
`define PORT_NUM_W          16
`define UDP_LENGTH_W        16
`define UDP_HDR_BYTES       8

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// NoC and MAC side
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// the MAC interface is as wide as one flit
`define NOC_DATA_WIDTH      128
`define NOC_DATA_BYTES_W    4
`define PADBYTES_W          4
`define XY_WIDTH            4
`define FBITS_W             4
`define MSG_LEN_W           8

// fbits of the interface this tile sends from
`define PKT_IF_FBITS        4'd2

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// port table
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define PORT_TABLE_DEPTH    8
`define PORT_TABLE_IDX_W    3

`endif
